// File: vlog.f
rtl/clint_pkg.sv
rtl/clint_reg_if.sv
rtl/clint_axi_slave.sv
rtl/clint_regs.sv
rtl/clint_top.sv
dv/clint_tb.sv

// File: Bender.yml
package:
  name: clint

sources:
  - rtl/clint_pkg.sv
  - rtl/clint_reg_if.sv
  - rtl/clint_axi_slave.sv
  - rtl/clint_regs.sv
  - rtl/clint_top.sv
  - target: test
    files:
      - dv/clint_tb.sv

// File: dv/clint_tb.sv
`timescale 1ns/100ps

module clint_tb;
    import clint_pkg::*;

    localparam int timeout_cycles = 6000;  // about 1500 for the tests and 300 for the irq wait

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic [15:0] s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [63:0] s_axi_wdata;
    logic [7:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [15:0] s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [63:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        timer_irq;
    logic        soft_irq;

    logic [31:0] lfsr = 32'h6475_8b6a;
    logic [63:0] exp_cmp;  // model of mtimecmp
    int          cycles = 0;

    clint_top #(.addr_width(16)) dut_i (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    always @(posedge S_AXI_ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] %s: got 0x%016h, expected 0x%016h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // high words come back in the upper lane
    task automatic check_reg(input clint_reg_e sel, input logic [63:0] got, input logic [31:0] word);
        logic [63:0] exp;
        exp = (sel == REG_MTIMECMP_HI || sel == REG_MTIME_HI) ? {word, 32'h0} : {32'h0, word};
        check_data($sformatf("s_axi_rdata (%s)", sel.name()), got, exp);
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input bit aw_first, input int b_delay);
        @(negedge S_AXI_ACLK);
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_wvalid  = !aw_first;
        while (!s_axi_awready) @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        s_axi_awvalid = 1'b0;
        if (aw_first) begin
            s_axi_wvalid = 1'b1;
            while (!s_axi_wready) @(negedge S_AXI_ACLK);
            @(negedge S_AXI_ACLK);
        end
        s_axi_wvalid = 1'b0;
        while (!s_axi_bvalid) @(negedge S_AXI_ACLK);
        check_bit("s_axi_bresp", s_axi_bresp, RESP_OKAY);
        repeat (b_delay) begin
            check_bit("s_axi_awready", s_axi_awready, 1'b0);  // held off by pending B
            check_bit("s_axi_wready", s_axi_wready, 1'b0);
            check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);
            @(negedge S_AXI_ACLK);
        end
        s_axi_bready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, input int r_delay, output logic [63:0] data);
        logic [63:0] first;
        @(negedge S_AXI_ACLK);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!s_axi_arready) @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) @(negedge S_AXI_ACLK);
        first = s_axi_rdata;
        repeat (r_delay) begin
            check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
            check_bit("s_axi_arready", s_axi_arready, 1'b0);  // next AR has to wait
            check_data("s_axi_rdata", s_axi_rdata, first);
            @(negedge S_AXI_ACLK);
        end
        check_bit("s_axi_rresp", s_axi_rresp, RESP_OKAY);
        data = s_axi_rdata;
        s_axi_rready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_rready = 1'b0;
    endtask

    task automatic test_reset();
        logic [63:0] rd;
        check_bit("soft_irq", soft_irq, 1'b0);
        check_bit("timer_irq", timer_irq, 1'b0);
        axi_read(CLINT_MSIP_ADDR, 0, rd);
        check_reg(REG_MSIP, rd, 32'h0);
        axi_read(CLINT_MTIMECMP_ADDR, 0, rd);
        check_reg(REG_MTIMECMP_LO, rd, 32'hFFFF_FFFF);
        axi_read(CLINT_MTIMECMP_ADDR_H, 0, rd);
        check_reg(REG_MTIMECMP_HI, rd, 32'hFFFF_FFFF);
    endtask

    task automatic test_msip();
        logic [63:0] rd;
        axi_write(CLINT_MSIP_ADDR, 64'h1, 8'h01, 1'b1, 0);
        check_bit("soft_irq", soft_irq, 1'b1);
        axi_read(CLINT_MSIP_ADDR, 0, rd);
        check_reg(REG_MSIP, rd, 32'h1);
        axi_write(CLINT_MSIP_ADDR, 64'h0, 8'h0E, 1'b0, 0);  // byte 0 not strobed
        check_bit("soft_irq", soft_irq, 1'b1);
        axi_read(CLINT_MSIP_ADDR, 0, rd);
        check_reg(REG_MSIP, rd, 32'h1);
        axi_write(CLINT_MSIP_ADDR, 64'h0, 8'h01, 1'b0, 1);
        check_bit("soft_irq", soft_irq, 1'b0);
        axi_read(CLINT_MSIP_ADDR, 0, rd);
        check_reg(REG_MSIP, rd, 32'h0);
    endtask

    task automatic test_mtimecmp();
        logic [63:0] rd;
        logic [31:0] word;
        logic [31:0] junk;
        logic [3:0]  strb;
        logic        hi;
        bit          aw_first;
        int          b_delay;
        int          base;
        for (int n = 0; n < 12; n++) begin
            hi       = rand_bits(1);
            word     = rand_bits(32);
            junk     = rand_bits(32);  // other lane is ignored
            strb     = rand_bits(4);
            aw_first = rand_bits(1);
            b_delay  = rand_bits(2);
            base     = hi ? 32 : 0;
            axi_write(hi ? CLINT_MTIMECMP_ADDR_H : CLINT_MTIMECMP_ADDR,
                      hi ? {word, junk} : {junk, word},
                      hi ? {strb, 4'h0} : {4'h0, strb}, aw_first, b_delay);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    exp_cmp[base + b*8 +: 8] = word[b*8 +: 8];
                end
            end
            axi_read(CLINT_MTIMECMP_ADDR, 0, rd);
            check_reg(REG_MTIMECMP_LO, rd, exp_cmp[31:0]);
            axi_read(CLINT_MTIMECMP_ADDR_H, 0, rd);
            check_reg(REG_MTIMECMP_HI, rd, exp_cmp[63:32]);
        end
    endtask

    task automatic test_backpressure();
        logic [63:0] rd;
        for (int n = 0; n < 4; n++) begin
            axi_read(CLINT_MTIMECMP_ADDR_H, 1 + rand_bits(3), rd);
            check_reg(REG_MTIMECMP_HI, rd, exp_cmp[63:32]);
            axi_read(CLINT_MTIMECMP_ADDR, 1 + rand_bits(3), rd);
            check_reg(REG_MTIMECMP_LO, rd, exp_cmp[31:0]);
            axi_write(CLINT_MSIP_ADDR, 64'h0, 8'h01, rand_bits(1), 1 + rand_bits(3));
        end
    endtask

    task automatic test_mtime();
        logic [63:0] rd;
        logic [31:0] t0;
        logic [31:0] val;
        axi_read(CLINT_MTIME_ADDR, 0, rd);
        t0 = rd[31:0];
        axi_read(CLINT_MTIME_ADDR, 0, rd);
        if (rd[31:0] <= t0) begin
            stop_run("mtime low word did not increase between two reads");
        end
        val = rand_bits(31);  // top bit clear keeps mtime below an all-ones mtimecmp_hi
        axi_write(CLINT_MTIME_ADDR_H, {val, 32'h0}, 8'hF0, 1'b0, 0);
        axi_read(CLINT_MTIME_ADDR_H, 0, rd);
        check_reg(REG_MTIME_HI, rd, val);
        axi_read(16'h2000, 0, rd);
        check_reg(REG_NONE, rd, 32'h0);
        axi_read(16'h2004, 0, rd);
        check_reg(REG_NONE, rd, 32'h0);
    endtask

    task automatic test_timer();
        logic [63:0] rd;
        logic [63:0] now;
        logic [63:0] cmp;
        int          waited;
        axi_read(CLINT_MTIME_ADDR_H, 0, rd);
        now[63:32] = rd[63:32];
        axi_read(CLINT_MTIME_ADDR, 0, rd);
        now[31:0] = rd[31:0];
        cmp = now + 64'd200;
        // park the high word first so no transient compare fires
        axi_write(CLINT_MTIMECMP_ADDR_H, 64'hFFFF_FFFF_0000_0000, 8'hF0, 1'b0, 0);
        axi_write(CLINT_MTIMECMP_ADDR, {32'h0, cmp[31:0]}, 8'h0F, 1'b0, 0);
        axi_write(CLINT_MTIMECMP_ADDR_H, {cmp[63:32], 32'h0}, 8'hF0, 1'b1, 0);
        check_bit("timer_irq", timer_irq, 1'b0);
        waited = 0;
        while (!timer_irq && waited < 300) begin
            waited++;
            @(negedge S_AXI_ACLK);
        end
        if (!timer_irq) begin
            stop_run("timer_irq did not rise within 300 cycles of the mtimecmp write");
        end
        axi_write(CLINT_MTIMECMP_ADDR_H, 64'hFFFF_FFFF_0000_0000, 8'hF0, 1'b0, 0);
        check_bit("timer_irq", timer_irq, 1'b0);
    endtask

    initial begin
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awprot  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        exp_cmp       = '1;
        repeat (5) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        test_reset();
        test_msip();
        test_mtimecmp();
        test_backpressure();
        test_mtime();
        test_timer();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: rtl/clint_top.sv
`timescale 1ns/100ps

module clint_top #(
    parameter int addr_width = 16
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic [addr_width-1:0] s_axi_awaddr,
    input  logic [2:0]            s_axi_awprot,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  logic [63:0]           s_axi_wdata,
    input  logic [7:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    input  logic [addr_width-1:0] s_axi_araddr,
    input  logic [2:0]            s_axi_arprot,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [63:0]           s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    output logic                  timer_irq,
    output logic                  soft_irq
);

    clint_reg_if reg_if ();

    clint_axi_slave #(
        .addr_width(addr_width)
    ) axi_slave_i (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .s_axi_awaddr (s_axi_awaddr),
        .s_axi_awprot (s_axi_awprot),
        .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready),
        .s_axi_wdata  (s_axi_wdata),
        .s_axi_wstrb  (s_axi_wstrb),
        .s_axi_wvalid (s_axi_wvalid),
        .s_axi_wready (s_axi_wready),
        .s_axi_bresp  (s_axi_bresp),
        .s_axi_bvalid (s_axi_bvalid),
        .s_axi_bready (s_axi_bready),
        .s_axi_araddr (s_axi_araddr),
        .s_axi_arprot (s_axi_arprot),
        .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready),
        .s_axi_rdata  (s_axi_rdata),
        .s_axi_rresp  (s_axi_rresp),
        .s_axi_rvalid (s_axi_rvalid),
        .s_axi_rready (s_axi_rready),
        .reg_bus      (reg_if.bus)
    );

    clint_regs regs_i (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .reg_bus      (reg_if.regs),
        .timer_irq    (timer_irq),
        .soft_irq     (soft_irq)
    );

endmodule

// File: rtl/clint_regs.sv
`timescale 1ns/100ps

module clint_regs (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    clint_reg_if.regs reg_bus,
    output logic      timer_irq,
    output logic      soft_irq
);
    import clint_pkg::*;

    logic        msip;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [31:0] rd_word;

    // byte lanes with strobe set take the new data
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            msip     <= 1'b0;
            mtimecmp <= '1;  // no timer irq out of reset
        end else if (reg_bus.wr_en) begin
            case (reg_bus.wr_sel)
                REG_MSIP: begin
                    if (reg_bus.wr_strb[0]) begin
                        msip <= reg_bus.wr_data[0];
                    end
                end
                REG_MTIMECMP_LO: begin
                    mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], reg_bus.wr_data,
                                                  reg_bus.wr_strb);
                end
                REG_MTIMECMP_HI: begin
                    mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], reg_bus.wr_data,
                                                   reg_bus.wr_strb);
                end
                default: ;
            endcase
        end
    end

    // free-running, a write to either word holds the count for that cycle
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            mtime <= '0;
        end else if (reg_bus.wr_en && reg_bus.wr_sel == REG_MTIME_LO) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], reg_bus.wr_data, reg_bus.wr_strb);
        end else if (reg_bus.wr_en && reg_bus.wr_sel == REG_MTIME_HI) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], reg_bus.wr_data, reg_bus.wr_strb);
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (reg_bus.rd_en) begin
            case (reg_bus.rd_sel)
                REG_MSIP:        rd_word <= {31'b0, msip};
                REG_MTIMECMP_LO: rd_word <= mtimecmp[31:0];
                REG_MTIMECMP_HI: rd_word <= mtimecmp[63:32];
                REG_MTIME_LO:    rd_word <= mtime[31:0];
                REG_MTIME_HI:    rd_word <= mtime[63:32];
                default:         rd_word <= 32'h0;  // unmapped
            endcase
        end
    end

    assign reg_bus.rd_data = rd_word;

    assign timer_irq = (mtime >= mtimecmp);
    assign soft_irq  = msip;

endmodule

// File: rtl/clint_axi_slave.sv
`timescale 1ns/100ps

module clint_axi_slave #(
    parameter int addr_width = 16
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic [addr_width-1:0] s_axi_awaddr,
    input  logic [2:0]            s_axi_awprot,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  logic [63:0]           s_axi_wdata,
    input  logic [7:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    input  logic [addr_width-1:0] s_axi_araddr,
    input  logic [2:0]            s_axi_arprot,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [63:0]           s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    clint_reg_if.bus              reg_bus
);
    import clint_pkg::*;

    wr_state_e             wr_state;
    rd_state_e             rd_state;
    logic [addr_width-1:0] awaddr_q;
    logic [15:0]           wr_addr;
    logic                  wr_lane_hi;
    logic                  rd_lane_hi;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  ar_hs;
    logic                  r_hs;

    // word address decode, bits 1:0 ignored
    function automatic clint_reg_e decode(input logic [15:0] addr);
        clint_reg_e sel;
        case (addr[15:2])
            CLINT_MSIP_ADDR[15:2]:       sel = REG_MSIP;
            CLINT_MTIMECMP_ADDR[15:2]:   sel = REG_MTIMECMP_LO;
            CLINT_MTIMECMP_ADDR_H[15:2]: sel = REG_MTIMECMP_HI;
            CLINT_MTIME_ADDR[15:2]:      sel = REG_MTIME_LO;
            CLINT_MTIME_ADDR_H[15:2]:    sel = REG_MTIME_HI;
            default:                     sel = REG_NONE;
        endcase
        return sel;
    endfunction

    assign s_axi_awready = (wr_state == WR_ADDR);
    // W only taken together with or after its AW
    assign s_axi_wready  = ((wr_state == WR_ADDR) && s_axi_awvalid) || (wr_state == WR_DATA);
    assign s_axi_bvalid  = (wr_state == WR_RESP);
    assign s_axi_bresp   = RESP_OKAY;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;

    assign wr_addr    = (wr_state == WR_DATA) ? awaddr_q[15:0] : s_axi_awaddr[15:0];
    assign wr_lane_hi = wr_addr[2];

    assign reg_bus.wr_en   = w_hs;
    assign reg_bus.wr_sel  = decode(wr_addr);
    assign reg_bus.wr_data = wr_lane_hi ? s_axi_wdata[63:32] : s_axi_wdata[31:0];
    assign reg_bus.wr_strb = wr_lane_hi ? s_axi_wstrb[7:4] : s_axi_wstrb[3:0];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: wr_state <= WR_ADDR;
                WR_ADDR: begin
                    if (aw_hs) begin
                        wr_state <= s_axi_wvalid ? WR_RESP : WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (s_axi_bready) begin
                        wr_state <= WR_ADDR;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            awaddr_q <= s_axi_awaddr;  // used if W comes later
        end
    end

    assign s_axi_arready = (rd_state == RD_ADDR);
    assign s_axi_rvalid  = (rd_state == RD_DATA);
    assign s_axi_rresp   = RESP_OKAY;

    assign ar_hs = s_axi_arvalid && s_axi_arready;
    assign r_hs  = s_axi_rvalid && s_axi_rready;

    assign reg_bus.rd_en  = ar_hs;
    assign reg_bus.rd_sel = decode(s_axi_araddr[15:0]);

    // word goes back in the lane it was addressed in
    assign s_axi_rdata = rd_lane_hi ? {reg_bus.rd_data, 32'h0} : {32'h0, reg_bus.rd_data};

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: rd_state <= RD_ADDR;
                RD_ADDR: begin
                    if (ar_hs) begin
                        rd_state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_hs) begin
                        rd_state <= RD_ADDR;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) begin
            rd_lane_hi <= s_axi_araddr[2];
        end
    end

endmodule

// File: rtl/clint_reg_if.sv
`timescale 1ns/100ps

interface clint_reg_if;
    import clint_pkg::*;

    logic        wr_en;    // one-cycle pulse
    clint_reg_e  wr_sel;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        rd_en;    // one-cycle pulse
    clint_reg_e  rd_sel;
    logic [31:0] rd_data;  // valid the cycle after rd_en

    modport bus (
        output wr_en, wr_sel, wr_data, wr_strb, rd_en, rd_sel,
        input  rd_data
    );

    modport regs (
        input  wr_en, wr_sel, wr_data, wr_strb, rd_en, rd_sel,
        output rd_data
    );

endinterface

// File: rtl/clint_pkg.sv
package clint_pkg;

    // register map, one hart
    localparam logic [15:0] CLINT_MSIP_ADDR       = 16'h0000;
    localparam logic [15:0] CLINT_MTIMECMP_ADDR   = 16'h4000;
    localparam logic [15:0] CLINT_MTIMECMP_ADDR_H = 16'h4004;
    localparam logic [15:0] CLINT_MTIME_ADDR      = 16'hBFF8;
    localparam logic [15:0] CLINT_MTIME_ADDR_H    = 16'hBFFC;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // register picked by the address decoder
    typedef enum logic [2:0] {
        REG_NONE,
        REG_MSIP,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI
    } clint_reg_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,  // address held, waiting for W
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

endpackage
